// ==== compile.f ====
design/iu_pkg.sv
design/iu_ex1_fwd_mux.sv
design/iu_ex1_ex2_pipe.sv
design/iu_ex2_wb_arb.sv
design/iu_retire_ctrl.sv
design/iu_ctrl_top.sv
tb/iu_ctrl_assert.sv
tb/iu_ctrl_tb.sv

// ==== Makefile ====
TOP := iu_ctrl_tb

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): compile.f $(wildcard design/*.sv tb/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

// ==== tb/iu_ctrl_tb.sv ====
// Random self-checking testbench for the IU control top level; run through compile.f
module iu_ctrl_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import iu_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 4;
  localparam int NUM_CYCLES = 4000;

  logic                iu_ex1_fwd_dp_clk = 1'b0;
  logic                cpurst_b;
  ex1_inst_t           ex1_inst;
  unit_fwd_t           div_ex1, alu_ex1, bju_ex1, lsu_ex1, xocc_ex1;
  preg_t               lsu_ex1_preg;
  logic                mul_ex1_cmplt_dp, alu_cmplt, mul_cmplt, div_cmplt, inst_len, split;
  logic                spec_expt_pending, spec_halt_pending, flush;
  logic                mul_ex2_inst_vld, mul_ex2_rslt_vld;
  data_t               mul_ex2_rslt;
  logic                lsu_wb_valid, div_wb_valid;
  wb_payload_t         lsu_wb, div_wb;
  logic                bju_stall, div_stall, bju_no_op, div_itering;
  fwd_bus_t            ex1_fwd, wb;
  logic                ex2_rd_pair, lsu_wb_ready, div_wb_ready, ex2_inst_vld, ex2_div_vld;
  logic                rtu_cmplt, rtu_cmplt_dp, rtu_inst_vld, rtu_inst_len, rtu_split;
  logic                idu_ex1_stall, no_op;

  logic [31:0] rng;
  // Reference copy of the EX1/EX2 register
  logic        m_vld;
  preg_t       m_preg;
  data_t       m_data;
  logic        m_rd_pair;
  logic        m_loaded;

  iu_ctrl_top DUT (.*);

  bind iu_ctrl_top iu_ctrl_assert u_grant_assert (
    .iu_ex1_fwd_dp_clk (iu_ex1_fwd_dp_clk),
    .cpurst_b          (cpurst_b),
    .wb_vld            (wb.vld),
    .lsu_wb_valid      (lsu_wb_valid),
    .lsu_wb_ready      (lsu_wb_ready),
    .div_wb_valid      (div_wb_valid),
    .div_wb_ready      (div_wb_ready),
    .ex2_inst_vld      (ex2_inst_vld),
    .ex2_div_vld       (ex2_div_vld)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_random(output logic [31:0] value);
    rng   = xorshift32(rng);
    value = rng;
  endtask

  task automatic stop_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
    else
    begin
      $display("Mismatch at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  // ==========================================================================
  // Reference model
  // ==========================================================================
  function automatic fwd_bus_t fwd_ref();
    fwd_sel_t sel;
    fwd_bus_t f;
    sel           = '0;
    sel[SEL_DIV]  = div_ex1.cmplt_dp;
    sel[SEL_MUL]  = mul_ex1_cmplt_dp;
    sel[SEL_BJU]  = bju_ex1.cmplt_dp;
    sel[SEL_ALU]  = alu_ex1.cmplt_dp;
    sel[SEL_LSU]  = lsu_ex1.cmplt_dp;
    sel[SEL_XOCC] = xocc_ex1.cmplt_dp;
    f = '0;
    if ($countones(sel) == 1)
    begin
      f.preg = sel[SEL_LSU] ? lsu_ex1_preg : ex1_inst.dst_preg;
      case (1'b1)
        sel[SEL_DIV]: {f.vld, f.data} = {div_ex1.fwd_vld, div_ex1.data};
        sel[SEL_MUL]: {f.vld, f.data} = {1'b0, alu_ex1.data};
        sel[SEL_BJU]: {f.vld, f.data} = {bju_ex1.fwd_vld, bju_ex1.data};
        sel[SEL_ALU]: {f.vld, f.data} = {alu_ex1.fwd_vld, alu_ex1.data};
        sel[SEL_LSU]: {f.vld, f.data} = {lsu_ex1.fwd_vld, lsu_ex1.data};
        default:      {f.vld, f.data} = {xocc_ex1.fwd_vld, xocc_ex1.data};
      endcase
    end
    return f;
  endfunction

  function automatic logic rslt_vld_ref();
    logic writes;
    writes = bju_ex1.fwd_vld
           | (ex1_inst.vld & ex1_inst.wb_vld & (ex1_inst.alu_sel | ex1_inst.xocc_sel));
    return writes & ~spec_expt_pending & ~spec_halt_pending;
  endfunction

  function automatic logic lsu_ready_ref();
    return ~(m_vld | mul_ex2_inst_vld);
  endfunction

  function automatic logic div_ready_ref();
    return lsu_ready_ref() & ~lsu_wb_valid;
  endfunction

  function automatic fwd_bus_t wb_ref();
    fwd_bus_t w;
    w = '0;
    if (m_vld)
      w = {1'b1, m_preg, m_data};
    else if (mul_ex2_rslt_vld)
      w = {1'b1, m_preg, mul_ex2_rslt};
    else if (lsu_wb_valid & lsu_ready_ref())
      w = {1'b1, lsu_wb.preg, lsu_wb.data};
    else if (div_wb_valid & div_ready_ref())
      w = {1'b1, div_wb.preg, div_wb.data};
    return w;
  endfunction

  // Advance the model with the inputs of the cycle that just ended
  task automatic update_model(output logic lsu_done, output logic div_done);
    fwd_bus_t fwd;
    logic     rslt_vld;
    fwd      = fwd_ref();
    rslt_vld = rslt_vld_ref();
    lsu_done = lsu_wb_valid & lsu_ready_ref();
    div_done = div_wb_valid & div_ready_ref();
    if (rslt_vld | (ex1_inst.vld & (ex1_inst.alu_sel | ex1_inst.mul_sel)))
    begin
      m_preg    = fwd.preg;
      m_rd_pair = ex1_inst.rd_pair;
      m_loaded  = 1'b1;
    end
    if (rslt_vld)
      m_data = fwd.data;
    m_vld = rslt_vld & ~flush;
  endtask

  // ==========================================================================
  // Stimulus
  // ==========================================================================
  task automatic drive_inputs(input logic lsu_done, input logic div_done);
    logic [31:0] r;
    logic [31:0] s;
    logic [5:0]  sel;
    logic        mul_issue;
    logic        mul_next;
    mul_issue = ex1_inst.vld & ex1_inst.mul_sel;
    next_random(r);
    // Mostly one completing unit and now and then any pattern
    if (r[3:0] == 4'd0)
      sel = r[9:4];
    else
      sel = 6'b000001 << (r[12:10] % 3'd6);
    div_ex1.cmplt_dp  <= sel[SEL_DIV];
    mul_ex1_cmplt_dp  <= sel[SEL_MUL];
    bju_ex1.cmplt_dp  <= sel[SEL_BJU];
    alu_ex1.cmplt_dp  <= sel[SEL_ALU];
    lsu_ex1.cmplt_dp  <= sel[SEL_LSU];
    xocc_ex1.cmplt_dp <= sel[SEL_XOCC];
    mul_next = r[13] & (r[15:14] == 2'd1);
    ex1_inst.vld      <= r[13];
    ex1_inst.alu_sel  <= (r[15:14] == 2'd0);
    ex1_inst.mul_sel  <= (r[15:14] == 2'd1);
    ex1_inst.xocc_sel <= (r[15:14] == 2'd2);
    ex1_inst.wb_vld   <= r[16];
    ex1_inst.rd_pair  <= r[17];
    ex1_inst.dst_preg <= r[23:18];
    lsu_ex1_preg      <= r[29:24];
    // No EX1 result beside a multiply so its EX2 slot stays free
    bju_ex1.fwd_vld   <= r[30] & ~mul_next;
    next_random(r);
    div_ex1.fwd_vld   <= r[0];
    alu_ex1.fwd_vld   <= r[1];
    lsu_ex1.fwd_vld   <= r[2];
    xocc_ex1.fwd_vld  <= r[3];
    flush             <= (r[7:4] == 4'd0);
    spec_expt_pending <= (r[10:8] == 3'd0);
    spec_halt_pending <= (r[13:11] == 3'd0);
    alu_cmplt         <= r[14];
    mul_cmplt         <= r[15];
    div_cmplt         <= r[16];
    inst_len          <= r[17];
    split             <= r[18];
    bju_stall         <= r[19];
    div_stall         <= r[20];
    bju_no_op         <= r[21] | r[22];
    div_itering       <= r[23] & r[24];
    mul_ex2_inst_vld  <= mul_issue;
    mul_ex2_rslt_vld  <= mul_issue & (r[25] | r[26]);
    next_random(r);
    next_random(s);
    div_ex1.data      <= r;
    alu_ex1.data      <= s;
    bju_ex1.data      <= r ^ s;
    lsu_ex1.data      <= {r[15:0], s[15:0]};
    xocc_ex1.data     <= {s[31:16], r[31:16]};
    mul_ex2_rslt      <= r + s;
    // Offers hold until their grant
    if (!lsu_wb_valid | lsu_done)
    begin
      next_random(r);
      next_random(s);
      lsu_wb_valid <= r[0];
      lsu_wb.preg  <= r[6:1];
      lsu_wb.data  <= s;
    end
    if (!div_wb_valid | div_done)
    begin
      next_random(r);
      next_random(s);
      div_wb_valid <= r[0] & r[1];
      div_wb.preg  <= r[7:2];
      div_wb.data  <= s;
    end
  endtask

  initial
  begin
    forever #(CLK_PERIOD / 2) iu_ex1_fwd_dp_clk = ~iu_ex1_fwd_dp_clk;
  end

  initial
  begin
    logic lsu_done;
    logic div_done;
    rng       = 32'h3b042261;
    m_vld     = 1'b0;
    m_preg    = '0;
    m_data    = '0;
    m_rd_pair = 1'b0;
    m_loaded  = 1'b0;
    cpurst_b          <= 1'b0;
    ex1_inst          <= '0;
    div_ex1           <= '0;
    alu_ex1           <= '0;
    bju_ex1           <= '0;
    lsu_ex1           <= '0;
    xocc_ex1          <= '0;
    lsu_ex1_preg      <= '0;
    mul_ex1_cmplt_dp  <= 1'b0;
    alu_cmplt         <= 1'b0;
    mul_cmplt         <= 1'b0;
    div_cmplt         <= 1'b0;
    inst_len          <= 1'b0;
    split             <= 1'b0;
    spec_expt_pending <= 1'b0;
    spec_halt_pending <= 1'b0;
    flush             <= 1'b0;
    mul_ex2_inst_vld  <= 1'b0;
    mul_ex2_rslt_vld  <= 1'b0;
    mul_ex2_rslt      <= '0;
    lsu_wb_valid      <= 1'b0;
    lsu_wb            <= '0;
    div_wb_valid      <= 1'b0;
    div_wb            <= '0;
    bju_stall         <= 1'b0;
    div_stall         <= 1'b0;
    bju_no_op         <= 1'b0;
    div_itering       <= 1'b0;
    repeat (RST_CYCLES) @(posedge iu_ex1_fwd_dp_clk);
    cpurst_b <= 1'b1;
    repeat (NUM_CYCLES)
    begin
      @(posedge iu_ex1_fwd_dp_clk);
      update_model(lsu_done, div_done);
      drive_inputs(lsu_done, div_done);
    end
    @(posedge iu_ex1_fwd_dp_clk);
    $display("Simulation finished: PASS");
    $finish;
  end

  // ==========================================================================
  // Output checks at the falling edge where everything has settled
  // ==========================================================================
  always @(negedge iu_ex1_fwd_dp_clk)
  begin : check_outputs
    fwd_bus_t exp_wb;
    exp_wb = wb_ref();
    compare("ex1_fwd", 64'(ex1_fwd), 64'(fwd_ref()));
    compare("wb", 64'(wb), 64'(exp_wb));
    compare("lsu_wb_ready", 64'(lsu_wb_ready), 64'(lsu_ready_ref()));
    compare("div_wb_ready", 64'(div_wb_ready), 64'(div_ready_ref()));
    compare("ex2_inst_vld", 64'(ex2_inst_vld), 64'(m_vld | mul_ex2_inst_vld));
    compare("ex2_div_vld", 64'(ex2_div_vld), 64'(div_wb_valid & div_ready_ref()));
    if (m_loaded)
      compare("ex2_rd_pair", 64'(ex2_rd_pair), 64'(m_rd_pair));
    compare("rtu_cmplt", 64'(rtu_cmplt),
            64'(alu_cmplt | mul_cmplt | div_cmplt | xocc_ex1.cmplt_dp));
    compare("rtu_cmplt_dp", 64'(rtu_cmplt_dp),
            64'(alu_ex1.cmplt_dp | mul_ex1_cmplt_dp | div_ex1.cmplt_dp | xocc_ex1.cmplt_dp));
    compare("rtu_inst_vld", 64'(rtu_inst_vld), 64'(ex1_inst.vld));
    compare("rtu_inst_len", 64'(rtu_inst_len), 64'(inst_len));
    compare("rtu_split", 64'(rtu_split), 64'(split));
    compare("idu_ex1_stall", 64'(idu_ex1_stall), 64'(bju_stall | div_stall));
    compare("no_op", 64'(no_op),
            64'(~ex1_inst.vld & ~exp_wb.vld & ~mul_ex2_inst_vld & bju_no_op & ~div_itering));
  end

  initial
  begin
    #((RST_CYCLES + NUM_CYCLES + 100) * CLK_PERIOD);
    $display("Watchdog expired before the random run completed");
    stop_with_failure();
  end

endmodule

// ==== tb/iu_ctrl_assert.sv ====
// Concurrent grant and reset checks on the IU control top level, bound onto it by the testbench
module iu_ctrl_assert (
  input logic iu_ex1_fwd_dp_clk,
  input logic cpurst_b,
  input logic wb_vld,
  input logic lsu_wb_valid,
  input logic lsu_wb_ready,
  input logic div_wb_valid,
  input logic div_wb_ready,
  input logic ex2_inst_vld,
  input logic ex2_div_vld
);
  timeunit 1ns;
  timeprecision 1ps;

  // Write-back bus quiet in the cycle after a reset cycle
  assert property (@(posedge iu_ex1_fwd_dp_clk) !cpurst_b |=> !wb_vld)
    else $error("wb valid high in the cycle after reset");

  // Load/store granted only while no EX2 instruction owns the port
  assert property (@(posedge iu_ex1_fwd_dp_clk) disable iff (!cpurst_b)
    lsu_wb_ready == !ex2_inst_vld)
    else $error("lsu_wb_ready does not follow the EX2 instruction slot");

  // Divider ranks below load/store
  assert property (@(posedge iu_ex1_fwd_dp_clk) disable iff (!cpurst_b)
    div_wb_ready |-> lsu_wb_ready && !lsu_wb_valid)
    else $error("div_wb_ready high while load/store has priority");

  assert property (@(posedge iu_ex1_fwd_dp_clk) disable iff (!cpurst_b)
    ex2_div_vld |-> div_wb_valid && div_wb_ready)
    else $error("ex2_div_vld high without a divider transfer");

endmodule

// ==== design/iu_ctrl_top.sv ====
// Integer unit control and forwarding top level; wires the EX1 mux, pipe, EX2 arbiter and retire
module iu_ctrl_top (
  input  logic                iu_ex1_fwd_dp_clk,
  input  logic                cpurst_b,
  input  iu_pkg::ex1_inst_t   ex1_inst,
  input  iu_pkg::unit_fwd_t   div_ex1,
  input  iu_pkg::unit_fwd_t   alu_ex1,
  input  iu_pkg::unit_fwd_t   bju_ex1,
  input  iu_pkg::unit_fwd_t   lsu_ex1,
  input  iu_pkg::unit_fwd_t   xocc_ex1,
  input  iu_pkg::preg_t       lsu_ex1_preg,
  input  logic                mul_ex1_cmplt_dp,
  input  logic                alu_cmplt,
  input  logic                mul_cmplt,
  input  logic                div_cmplt,
  input  logic                inst_len,
  input  logic                split,
  input  logic                spec_expt_pending,
  input  logic                spec_halt_pending,
  input  logic                flush,
  input  logic                mul_ex2_inst_vld,
  input  logic                mul_ex2_rslt_vld,
  input  iu_pkg::data_t       mul_ex2_rslt,
  input  logic                lsu_wb_valid,
  input  iu_pkg::wb_payload_t lsu_wb,
  input  logic                div_wb_valid,
  input  iu_pkg::wb_payload_t div_wb,
  input  logic                bju_stall,
  input  logic                div_stall,
  input  logic                bju_no_op,
  input  logic                div_itering,
  output iu_pkg::fwd_bus_t    ex1_fwd,
  output logic                ex2_rd_pair,
  output iu_pkg::fwd_bus_t    wb,
  output logic                lsu_wb_ready,
  output logic                div_wb_ready,
  output logic                ex2_inst_vld,
  output logic                ex2_div_vld,
  output logic                rtu_cmplt,
  output logic                rtu_cmplt_dp,
  output logic                rtu_inst_vld,
  output logic                rtu_inst_len,
  output logic                rtu_split,
  output logic                idu_ex1_stall,
  output logic                no_op
);

  import iu_pkg::*;

  logic     ex1_rslt_vld;
  fwd_bus_t ex2_pipe;

  // ==========================================================================
  // EX1 stage
  // ==========================================================================
  iu_ex1_fwd_mux u_ex1_fwd_mux (
    .ex1_inst          (ex1_inst),
    .div_ex1           (div_ex1),
    .alu_ex1           (alu_ex1),
    .bju_ex1           (bju_ex1),
    .lsu_ex1           (lsu_ex1),
    .xocc_ex1          (xocc_ex1),
    .lsu_ex1_preg      (lsu_ex1_preg),
    .mul_ex1_cmplt_dp  (mul_ex1_cmplt_dp),
    .spec_expt_pending (spec_expt_pending),
    .spec_halt_pending (spec_halt_pending),
    .ex1_fwd           (ex1_fwd),
    .ex1_rslt_vld      (ex1_rslt_vld)
  );

  iu_ex1_ex2_pipe u_ex1_ex2_pipe (
    .iu_ex1_fwd_dp_clk (iu_ex1_fwd_dp_clk),
    .cpurst_b          (cpurst_b),
    .flush             (flush),
    .ex1_fwd           (ex1_fwd),
    .ex1_rslt_vld      (ex1_rslt_vld),
    .ex1_inst          (ex1_inst),
    .ex2_pipe          (ex2_pipe),
    .ex2_rd_pair       (ex2_rd_pair)
  );

  // ==========================================================================
  // EX2 stage and retire report
  // ==========================================================================
  iu_ex2_wb_arb u_ex2_wb_arb (
    .ex2_pipe         (ex2_pipe),
    .mul_ex2_inst_vld (mul_ex2_inst_vld),
    .mul_ex2_rslt_vld (mul_ex2_rslt_vld),
    .mul_ex2_rslt     (mul_ex2_rslt),
    .lsu_wb_valid     (lsu_wb_valid),
    .lsu_wb           (lsu_wb),
    .div_wb_valid     (div_wb_valid),
    .div_wb           (div_wb),
    .lsu_wb_ready     (lsu_wb_ready),
    .div_wb_ready     (div_wb_ready),
    .wb               (wb),
    .ex2_inst_vld     (ex2_inst_vld),
    .ex2_div_vld      (ex2_div_vld)
  );

  // Coprocessor completion is its datapath completion bit
  iu_retire_ctrl u_retire_ctrl (
    .ex1_inst         (ex1_inst),
    .alu_cmplt        (alu_cmplt),
    .mul_cmplt        (mul_cmplt),
    .div_cmplt        (div_cmplt),
    .xocc_cmplt       (xocc_ex1.cmplt_dp),
    .alu_cmplt_dp     (alu_ex1.cmplt_dp),
    .mul_cmplt_dp     (mul_ex1_cmplt_dp),
    .div_cmplt_dp     (div_ex1.cmplt_dp),
    .inst_len         (inst_len),
    .split            (split),
    .bju_stall        (bju_stall),
    .div_stall        (div_stall),
    .bju_no_op        (bju_no_op),
    .div_itering      (div_itering),
    .wb_vld           (wb.vld),
    .mul_ex2_inst_vld (mul_ex2_inst_vld),
    .rtu_cmplt        (rtu_cmplt),
    .rtu_cmplt_dp     (rtu_cmplt_dp),
    .rtu_inst_vld     (rtu_inst_vld),
    .rtu_inst_len     (rtu_inst_len),
    .rtu_split        (rtu_split),
    .idu_ex1_stall    (idu_ex1_stall),
    .no_op            (no_op)
  );

endmodule

// ==== design/iu_retire_ctrl.sv ====
// Builds the EX1 completion report for retire, the EX1 stall to decode and the unit-idle flag
module iu_retire_ctrl (
  input  iu_pkg::ex1_inst_t ex1_inst,
  input  logic              alu_cmplt,
  input  logic              mul_cmplt,
  input  logic              div_cmplt,
  input  logic              xocc_cmplt,
  input  logic              alu_cmplt_dp,
  input  logic              mul_cmplt_dp,
  input  logic              div_cmplt_dp,
  input  logic              inst_len,
  input  logic              split,
  input  logic              bju_stall,
  input  logic              div_stall,
  input  logic              bju_no_op,
  input  logic              div_itering,
  input  logic              wb_vld,
  input  logic              mul_ex2_inst_vld,
  output logic              rtu_cmplt,
  output logic              rtu_cmplt_dp,
  output logic              rtu_inst_vld,
  output logic              rtu_inst_len,
  output logic              rtu_split,
  output logic              idu_ex1_stall,
  output logic              no_op
);

  logic ex1_idle;
  logic ex2_idle;

  // Coprocessor counts for both the control and datapath completion
  assign rtu_cmplt    = alu_cmplt | mul_cmplt | div_cmplt | xocc_cmplt;
  assign rtu_cmplt_dp = alu_cmplt_dp | mul_cmplt_dp | div_cmplt_dp | xocc_cmplt;

  assign rtu_inst_vld = ex1_inst.vld;
  assign rtu_inst_len = inst_len;
  assign rtu_split    = split;

  assign idu_ex1_stall = bju_stall | div_stall;

  // Idle only when both stages are empty and no multi-cycle op is running
  assign ex1_idle = ~ex1_inst.vld;
  assign ex2_idle = ~(wb_vld | mul_ex2_inst_vld);

  assign no_op = ex1_idle & ex2_idle & bju_no_op & ~div_itering;

endmodule

// ==== design/iu_ex2_wb_arb.sv ====
// EX2 write-back arbiter; grants the load/store and divider results behind the IU's own result
module iu_ex2_wb_arb (
  input  iu_pkg::fwd_bus_t    ex2_pipe,
  input  logic                mul_ex2_inst_vld,
  input  logic                mul_ex2_rslt_vld,
  input  iu_pkg::data_t       mul_ex2_rslt,
  input  logic                lsu_wb_valid,
  input  iu_pkg::wb_payload_t lsu_wb,
  input  logic                div_wb_valid,
  input  iu_pkg::wb_payload_t div_wb,
  output logic                lsu_wb_ready,
  output logic                div_wb_ready,
  output iu_pkg::fwd_bus_t    wb,
  output logic                ex2_inst_vld,
  output logic                ex2_div_vld
);

  import iu_pkg::*;

  logic lsu_xfer;
  logic div_xfer;

  // ==========================================================================
  // Grants
  // ==========================================================================
  // Priority is IU result or multiplier, then load/store, then divider
  assign ex2_inst_vld = ex2_pipe.vld | mul_ex2_inst_vld;

  assign lsu_wb_ready = ~ex2_inst_vld;
  assign div_wb_ready = ~ex2_inst_vld & ~lsu_wb_valid;

  assign lsu_xfer    = lsu_wb_valid & lsu_wb_ready;
  assign div_xfer    = div_wb_valid & div_wb_ready;
  assign ex2_div_vld = div_xfer;

  // ==========================================================================
  // Write-back mux
  // ==========================================================================
  always_comb
  begin
    wb     = '0;
    wb.vld = ex2_pipe.vld | mul_ex2_rslt_vld | lsu_xfer | div_xfer;
    if (ex2_pipe.vld)
    begin
      wb.preg = ex2_pipe.preg;
      wb.data = ex2_pipe.data;
    end
    else if (mul_ex2_rslt_vld)
    begin
      // Multiplier destination was captured by the EX1/EX2 register
      wb.preg = ex2_pipe.preg;
      wb.data = mul_ex2_rslt;
    end
    else if (lsu_xfer)
    begin
      wb.preg = lsu_wb.preg;
      wb.data = lsu_wb.data;
    end
    else if (div_xfer)
    begin
      wb.preg = div_wb.preg;
      wb.data = div_wb.data;
    end
  end

endmodule

// ==== design/iu_ex1_ex2_pipe.sv ====
// EX1 to EX2 result register; the valid bit resets and flushes, the payload only loads
module iu_ex1_ex2_pipe (
  input  logic              iu_ex1_fwd_dp_clk,
  input  logic              cpurst_b,
  input  logic              flush,
  input  iu_pkg::fwd_bus_t  ex1_fwd,
  input  logic              ex1_rslt_vld,
  input  iu_pkg::ex1_inst_t ex1_inst,
  output iu_pkg::fwd_bus_t  ex2_pipe,
  output logic              ex2_rd_pair
);

  import iu_pkg::*;

  logic  rslt_vld_q;
  preg_t dst_preg_q;
  data_t rslt_q;
  logic  rd_pair_q;
  logic  inst_pipe_down;
  logic  preg_load;

  // ALU and multiplier ops always carry their destination into EX2
  assign inst_pipe_down = ex1_inst.vld & (ex1_inst.alu_sel | ex1_inst.mul_sel);
  assign preg_load      = ex1_rslt_vld | inst_pipe_down;

  always_ff @(posedge iu_ex1_fwd_dp_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      rslt_vld_q <= 1'b0;
    end
    else if (flush)
    begin
      rslt_vld_q <= 1'b0;
    end
    else
    begin
      rslt_vld_q <= ex1_rslt_vld;
    end
  end

  // Payload holds unless loaded
  always_ff @(posedge iu_ex1_fwd_dp_clk)
  begin
    if (preg_load)
    begin
      dst_preg_q <= ex1_fwd.preg;
      rd_pair_q  <= ex1_inst.rd_pair;
    end
    if (ex1_rslt_vld)
    begin
      rslt_q <= ex1_fwd.data;
    end
  end

  assign ex2_pipe.vld  = rslt_vld_q;
  assign ex2_pipe.preg = dst_preg_q;
  assign ex2_pipe.data = rslt_q;
  assign ex2_rd_pair   = rd_pair_q;

endmodule

// ==== design/iu_ex1_fwd_mux.sv ====
// Picks the EX1 forward result sent back to decode and decides whether EX1 has a result to write
module iu_ex1_fwd_mux (
  input  iu_pkg::ex1_inst_t ex1_inst,
  input  iu_pkg::unit_fwd_t div_ex1,
  input  iu_pkg::unit_fwd_t alu_ex1,
  input  iu_pkg::unit_fwd_t bju_ex1,
  input  iu_pkg::unit_fwd_t lsu_ex1,
  input  iu_pkg::unit_fwd_t xocc_ex1,
  input  iu_pkg::preg_t     lsu_ex1_preg,
  input  logic              mul_ex1_cmplt_dp,
  input  logic              spec_expt_pending,
  input  logic              spec_halt_pending,
  output iu_pkg::fwd_bus_t  ex1_fwd,
  output logic              ex1_rslt_vld
);

  import iu_pkg::*;

  fwd_sel_t fwd_sel;
  logic     alu_rslt_vld;
  logic     xocc_rslt_vld;
  logic     spec_pending;

  // One completing unit per cycle, from the datapath completion bits
  assign fwd_sel[SEL_DIV]  = div_ex1.cmplt_dp;
  assign fwd_sel[SEL_MUL]  = mul_ex1_cmplt_dp;
  assign fwd_sel[SEL_BJU]  = bju_ex1.cmplt_dp;
  assign fwd_sel[SEL_ALU]  = alu_ex1.cmplt_dp;
  assign fwd_sel[SEL_LSU]  = lsu_ex1.cmplt_dp;
  assign fwd_sel[SEL_XOCC] = xocc_ex1.cmplt_dp;

  // ==========================================================================
  // Forward mux
  // ==========================================================================
  always_comb
  begin
    ex1_fwd = '0;
    if ($onehot(fwd_sel))
    begin
      ex1_fwd.preg = ex1_inst.dst_preg;
      if (fwd_sel[SEL_DIV])
      begin
        ex1_fwd.vld  = div_ex1.fwd_vld;
        ex1_fwd.data = div_ex1.data;
      end
      else if (fwd_sel[SEL_MUL])
      begin
        // Multiplier announces only its destination here and sends its data in EX2
        ex1_fwd.vld  = 1'b0;
        ex1_fwd.data = alu_ex1.data;
      end
      else if (fwd_sel[SEL_BJU])
      begin
        ex1_fwd.vld  = bju_ex1.fwd_vld;
        ex1_fwd.data = bju_ex1.data;
      end
      else if (fwd_sel[SEL_ALU])
      begin
        ex1_fwd.vld  = alu_ex1.fwd_vld;
        ex1_fwd.data = alu_ex1.data;
      end
      else if (fwd_sel[SEL_LSU])
      begin
        // Address generator carries its own destination
        ex1_fwd.vld  = lsu_ex1.fwd_vld;
        ex1_fwd.preg = lsu_ex1_preg;
        ex1_fwd.data = lsu_ex1.data;
      end
      else
      begin
        ex1_fwd.vld  = xocc_ex1.fwd_vld;
        ex1_fwd.data = xocc_ex1.data;
      end
    end
  end

  // ==========================================================================
  // Result valid toward EX2
  // ==========================================================================
  assign alu_rslt_vld  = ex1_inst.vld & ex1_inst.alu_sel & ex1_inst.wb_vld;
  assign xocc_rslt_vld = ex1_inst.vld & ex1_inst.xocc_sel & ex1_inst.wb_vld;
  assign spec_pending  = spec_expt_pending | spec_halt_pending;

  assign ex1_rslt_vld = (bju_ex1.fwd_vld | alu_rslt_vld | xocc_rslt_vld) & ~spec_pending;

endmodule

// ==== design/iu_pkg.sv ====
// Shared widths, forward-select bit positions and bus structs, imported by every IU control block
package iu_pkg;

  // ==========================================================================
  // Widths
  // ==========================================================================
  localparam int PREG_W = 6;
  localparam int DATA_W = 32;
  localparam int SEL_W  = 6;

  // Bit positions inside the one-hot EX1 forward select
  localparam int SEL_DIV  = 0;
  localparam int SEL_MUL  = 1;
  localparam int SEL_BJU  = 2;
  localparam int SEL_ALU  = 3;
  localparam int SEL_LSU  = 4;
  localparam int SEL_XOCC = 5;

  typedef logic [PREG_W-1:0] preg_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [SEL_W-1:0]  fwd_sel_t;

  // ==========================================================================
  // Bus structs
  // ==========================================================================
  // Decoded instruction sitting in EX1
  typedef struct packed {
    logic  vld;
    logic  alu_sel;
    logic  mul_sel;
    logic  xocc_sel;
    logic  wb_vld;
    logic  rd_pair;
    preg_t dst_preg;
  } ex1_inst_t;

  // One execution unit's EX1 forward offer
  typedef struct packed {
    logic  cmplt_dp;
    logic  fwd_vld;
    data_t data;
  } unit_fwd_t;

  // Forward or write-back result
  typedef struct packed {
    logic  vld;
    preg_t preg;
    data_t data;
  } fwd_bus_t;

  // Result waiting for an EX2 write-back grant
  typedef struct packed {
    preg_t preg;
    data_t data;
  } wb_payload_t;

endpackage
